//--- common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// =========================================================================
	// widths and instruction fields
	// =========================================================================
	localparam int data_w = 32;     // data path and address width.
	localparam int reg_aw = 5;
	localparam int instr_step = 4;  // pc advance per instruction.

	localparam int op_hi = 30;
	localparam int op_lo = 25;
	localparam int rt_hi = 24;
	localparam int rt_lo = 20;
	localparam int ra_hi = 19;
	localparam int ra_lo = 15;
	localparam int rb_hi = 14;      // also the 5-bit immediate.
	localparam int rb_lo = 10;
	localparam int sv_hi = 9;
	localparam int sv_lo = 8;
	localparam int sub_hi = 4;
	localparam int sub_lo = 0;
	localparam int imm15_hi = 14;
	localparam int imm20_hi = 19;

	// sub-operations of OP_ALU.
	localparam logic [4:0] sub_add = 5'h00;
	localparam logic [4:0] sub_sub = 5'h01;
	localparam logic [4:0] sub_and = 5'h02;
	localparam logic [4:0] sub_xor = 5'h03;
	localparam logic [4:0] sub_or = 5'h04;
	localparam logic [4:0] sub_subr = 5'h05;  // ra minus rt, result to rt.
	localparam logic [4:0] sub_srl = 5'h09;

	// =========================================================================
	// encodings
	// =========================================================================
	typedef enum logic [5:0] {
		OP_LWI  = 6'h02,
		OP_SWI  = 6'h0a,
		OP_ALU  = 6'h20,
		OP_MOVI = 6'h22,
		OP_SLLI = 6'h24,
		OP_ADDI = 6'h28,
		OP_ORI  = 6'h2c
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL
	} alu_op_e;

	typedef enum logic [1:0] {
		ST_FETCH,
		ST_EXEC,
		ST_MEM,
		ST_WB
	} state_e;

	typedef enum logic [1:0] {
		IMM_ZE5  = 2'b00,
		IMM_SE15 = 2'b01,
		IMM_ZE15 = 2'b10,
		IMM_SE20 = 2'b11
	} imm_ext_e;

	typedef enum logic [2:0] {
		SRC2_RB    = 3'b000,
		SRC2_IMM   = 3'b001,
		SRC2_OFS   = 3'b010,
		SRC2_RB_SV = 3'b011,
		SRC2_RT    = 3'b100
	} src2_e;

	typedef enum logic [1:0] {
		WSEL_ALU  = 2'b00,
		WSEL_SRC2 = 2'b01,
		WSEL_MEM  = 2'b10
	} wsel_e;

	// =========================================================================
	// bundles
	// =========================================================================
	typedef struct packed {
		alu_op_e           alu_op;
		imm_ext_e          imm_ext;
		src2_e             src2_sel;
		wsel_e             wb_sel;
		logic              reg_write;
		logic              mem_read;
		logic              mem_write;
		logic [1:0]        sv;
		logic [reg_aw-1:0] ra;
		logic [reg_aw-1:0] rb;
		logic [reg_aw-1:0] rt;
	} ctrl_t;

	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic [data_w-1:0] adr;
		logic [data_w-1:0] dat;
	} wb_m2s_t;

	typedef struct packed {
		logic              ack;
		logic [data_w-1:0] dat;
	} wb_s2m_t;

endpackage

`default_nettype wire

//--- control/instr_decoder.sv
`default_nettype none

module instr_decoder
	import cpu_pkg::*;
(
	input  wire [data_w-1:0] instr,
	output ctrl_t            ctrl
);

	opcode_e    opcode;
	logic [4:0] sub_op;

	assign opcode = opcode_e'(instr[op_hi:op_lo]);
	assign sub_op = instr[sub_hi:sub_lo];

	always_comb begin
		// defaults give a no-op.
		ctrl.alu_op    = ALU_ADD;
		ctrl.imm_ext   = IMM_SE15;
		ctrl.src2_sel  = SRC2_RB;
		ctrl.wb_sel    = WSEL_ALU;
		ctrl.reg_write = 1'b0;
		ctrl.mem_read  = 1'b0;
		ctrl.mem_write = 1'b0;
		ctrl.sv        = instr[sv_hi:sv_lo];
		ctrl.ra        = instr[ra_hi:ra_lo];
		ctrl.rb        = instr[rb_hi:rb_lo];
		ctrl.rt        = instr[rt_hi:rt_lo];

		case (opcode)
			OP_ALU: begin
				ctrl.reg_write = 1'b1;
				case (sub_op)
					sub_add: begin
						ctrl.alu_op = ALU_ADD;
						if (ctrl.sv != 2'b00)
							ctrl.src2_sel = SRC2_RB_SV; // rb scaled by sv.
					end
					sub_sub:  ctrl.alu_op = ALU_SUB;
					sub_subr: begin
						ctrl.alu_op   = ALU_SUB;
						ctrl.src2_sel = SRC2_RT;
					end
					sub_and:  ctrl.alu_op = ALU_AND;
					sub_or:   ctrl.alu_op = ALU_OR;
					sub_xor:  ctrl.alu_op = ALU_XOR;
					sub_srl:  ctrl.alu_op = ALU_SRL;
					default:  ctrl.reg_write = 1'b0; // unknown sub-op.
				endcase
			end
			OP_ADDI: begin
				ctrl.src2_sel  = SRC2_IMM;
				ctrl.reg_write = 1'b1;
			end
			OP_ORI: begin
				ctrl.alu_op    = ALU_OR;
				ctrl.imm_ext   = IMM_ZE15;
				ctrl.src2_sel  = SRC2_IMM;
				ctrl.reg_write = 1'b1;
			end
			OP_MOVI: begin
				ctrl.imm_ext   = IMM_SE20;
				ctrl.src2_sel  = SRC2_IMM;
				ctrl.wb_sel    = WSEL_SRC2; // bypasses the ALU.
				ctrl.reg_write = 1'b1;
			end
			OP_SLLI: begin
				ctrl.alu_op    = ALU_SLL;
				ctrl.imm_ext   = IMM_ZE5;
				ctrl.src2_sel  = SRC2_IMM;
				ctrl.reg_write = 1'b1;
			end
			OP_LWI: begin
				ctrl.src2_sel  = SRC2_OFS;
				ctrl.wb_sel    = WSEL_MEM;
				ctrl.reg_write = 1'b1;
				ctrl.mem_read  = 1'b1;
			end
			OP_SWI: begin
				ctrl.src2_sel  = SRC2_OFS;
				ctrl.mem_write = 1'b1;
			end
			default: begin
			end
		endcase
	end

	// a load and a store at once would confuse the bus sequence.
	always_comb begin
		a_mem_excl: assert (!(ctrl.mem_read && ctrl.mem_write))
			else $error("decoder: load and store both set");
	end

endmodule

`default_nettype wire

//--- control/bus_ctrl.sv
`default_nettype none

module bus_ctrl
	import cpu_pkg::*;
(
	input  wire                clk,
	input  wire                arst_n,
	output wb_m2s_t            wb_o,
	input  wire wb_s2m_t       wb_i,
	input  wire ctrl_t         ctrl,
	input  wire [data_w-1:0]   alu_result,
	input  wire [data_w-1:0]   store_data,
	output logic [data_w-1:0]  instr,
	output logic [data_w-1:0]  load_data,
	output logic               reg_we
);

	state_e            state;
	wb_m2s_t           wb_q;
	logic [data_w-1:0] pc;
	logic [data_w-1:0] pc_next;
	logic [data_w-1:0] ir;
	logic [data_w-1:0] load_q;
	logic              mem_op;

	assign pc_next = pc + instr_step;
	assign mem_op = ctrl.mem_read | ctrl.mem_write;

	// =========================================================================
	// sequencer and Wishbone master
	// =========================================================================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_FETCH;
			pc    <= '0;
			ir    <= '0;
			wb_q  <= '0;
		end else begin
			case (state)
				ST_FETCH: begin
					if (!wb_q.cyc) begin
						// first fetch after reset.
						wb_q.cyc <= 1'b1;
						wb_q.stb <= 1'b1;
						wb_q.we  <= 1'b0;
						wb_q.adr <= pc;
					end else if (wb_i.ack) begin
						ir       <= wb_i.dat;
						wb_q.cyc <= 1'b0;
						wb_q.stb <= 1'b0;
						state    <= ST_EXEC;
					end
				end
				ST_EXEC: begin
					wb_q.adr <= alu_result; // effective address.
					if (mem_op) begin
						wb_q.cyc <= 1'b1;
						wb_q.stb <= 1'b1;
						wb_q.we  <= ctrl.mem_write;
						wb_q.dat <= store_data;
						state    <= ST_MEM;
					end else begin
						state <= ST_WB;
					end
				end
				ST_MEM: begin
					if (wb_i.ack) begin
						wb_q.cyc <= 1'b0;
						wb_q.stb <= 1'b0;
						wb_q.we  <= 1'b0;
						state    <= ST_WB;
					end
				end
				ST_WB: begin
					pc       <= pc_next;
					wb_q.cyc <= 1'b1; // next fetch goes out at once.
					wb_q.stb <= 1'b1;
					wb_q.we  <= 1'b0;
					wb_q.adr <= pc_next;
					state    <= ST_FETCH;
				end
				default: state <= ST_FETCH;
			endcase
		end
	end

	// read data is valid in the ack cycle only.
	always_ff @(posedge clk) begin
		if (state == ST_MEM && wb_i.ack && !wb_q.we)
			load_q <= wb_i.dat;
	end

	assign reg_we = (state == ST_WB) && ctrl.reg_write;
	assign wb_o = wb_q;
	assign instr = ir;
	assign load_data = load_q;

	// =========================================================================
	// bus protocol checks
	// =========================================================================
	a_stb_cyc: assert property (@(posedge clk) disable iff (!arst_n)
		wb_q.stb |-> wb_q.cyc);

	a_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
		wb_q.stb && !wb_i.ack |=> $stable(wb_q.adr) && $stable(wb_q.we));

endmodule

`default_nettype wire

//--- datapath/reg_file.sv
`default_nettype none

module reg_file
	import cpu_pkg::*;
(
	input  wire                clk,
	input  wire                arst_n,
	input  wire [reg_aw-1:0]   ra,
	input  wire [reg_aw-1:0]   rb,
	input  wire [reg_aw-1:0]   rt,
	output logic [data_w-1:0]  ra_data,
	output logic [data_w-1:0]  rb_data,
	output logic [data_w-1:0]  rt_data,
	input  wire                we,
	input  wire [reg_aw-1:0]   wa,
	input  wire [data_w-1:0]   wd
);

	localparam int nregs = 1 << reg_aw;

	logic [data_w-1:0] regs [nregs];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < nregs; i++)
				regs[i] <= '0;
		end else if (we && wa != '0) begin
			regs[wa] <= wd; // r0 stays zero.
		end
	end

	// three asynchronous read ports.
	assign ra_data = regs[ra];
	assign rb_data = regs[rb];
	assign rt_data = regs[rt]; // store data and SRC2_RT.

endmodule

`default_nettype wire

//--- datapath/alu.sv
`default_nettype none

module alu
	import cpu_pkg::*;
(
	input  wire alu_op_e       op,
	input  wire [data_w-1:0]   src1,
	input  wire [data_w-1:0]   src2,
	output logic [data_w-1:0]  result
);

	logic [4:0] shamt;

	assign shamt = src2[4:0];

	always_comb begin
		case (op)
			ALU_ADD: result = src1 + src2;
			ALU_SUB: result = src1 - src2;
			ALU_AND: result = src1 & src2;
			ALU_OR:  result = src1 | src2;
			ALU_XOR: result = src1 ^ src2;
			ALU_SLL: result = src1 << shamt;
			ALU_SRL: result = src1 >> shamt; // logical.
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- datapath/muxs.sv
`default_nettype none

module muxs
	import cpu_pkg::*;
(
	input  wire [1:0]          sub_op_sv,
	input  wire [data_w-1:0]   reg_rb_data,
	input  wire [data_w-1:0]   reg_rt_data,
	input  wire [data_w-1:0]   mem_read_data,
	input  wire [data_w-1:0]   alu_output,
	input  wire [4:0]          imm_5bit,
	input  wire [14:0]         imm_15bit,
	input  wire [19:0]         imm_20bit,
	input  wire src2_e         select_alu_src2,
	input  wire imm_ext_e      select_imm_extend,
	input  wire wsel_e         select_write_reg,
	output logic [data_w-1:0]  alu_src2,
	output logic [data_w-1:0]  write_reg_data
);

	logic [data_w-1:0] imm;

	// immediate extension.
	always_comb begin
		case (select_imm_extend)
			IMM_ZE5:  imm = {{(data_w-5){1'b0}}, imm_5bit};
			IMM_SE15: imm = {{(data_w-15){imm_15bit[14]}}, imm_15bit};
			IMM_ZE15: imm = {{(data_w-15){1'b0}}, imm_15bit};
			IMM_SE20: imm = {{(data_w-20){imm_20bit[19]}}, imm_20bit};
			default:  imm = '0;
		endcase
	end

	// =========================================================================
	// second ALU operand
	// =========================================================================
	always_comb begin
		case (select_alu_src2)
			SRC2_RB:    alu_src2 = reg_rb_data;
			SRC2_IMM:   alu_src2 = imm;
			SRC2_OFS:   alu_src2 = {{(data_w-17){imm_15bit[14]}}, imm_15bit, 2'b00};
			SRC2_RB_SV: alu_src2 = reg_rb_data << sub_op_sv;
			SRC2_RT:    alu_src2 = reg_rt_data;
			default:    alu_src2 = '0;
		endcase
	end

	// write-back source.
	always_comb begin
		case (select_write_reg)
			WSEL_ALU:  write_reg_data = alu_output;
			WSEL_SRC2: write_reg_data = alu_src2; // MOVI.
			WSEL_MEM:  write_reg_data = mem_read_data;
			default:   write_reg_data = '0;
		endcase
	end

	always_comb begin
		a_src2_code: assert (select_alu_src2 inside
			{SRC2_RB, SRC2_IMM, SRC2_OFS, SRC2_RB_SV, SRC2_RT})
			else $error("muxs: undefined src2 select %0d", select_alu_src2);
	end

endmodule

`default_nettype wire

//--- verilog/cpu_top.sv
`default_nettype none

module cpu_top
	import cpu_pkg::*;
(
	input  wire          clk,
	input  wire          arst_n,
	output wb_m2s_t      wb_o,
	input  wire wb_s2m_t wb_i
);

	ctrl_t             ctrl;
	logic [data_w-1:0] instr;
	logic [data_w-1:0] load_data;
	logic              reg_we;
	logic [data_w-1:0] ra_data;
	logic [data_w-1:0] rb_data;
	logic [data_w-1:0] rt_data;
	logic [data_w-1:0] alu_src2;
	logic [data_w-1:0] alu_result;
	logic [data_w-1:0] write_reg_data;

	// =========================================================================
	// sequencing and bus
	// =========================================================================
	bus_ctrl u_bus_ctrl (
		.clk        (clk),
		.arst_n     (arst_n),
		.wb_o       (wb_o),
		.wb_i       (wb_i),
		.ctrl       (ctrl),
		.alu_result (alu_result),
		.store_data (rt_data),
		.instr      (instr),
		.load_data  (load_data),
		.reg_we     (reg_we)
	);

	instr_decoder u_decoder (
		.instr (instr),
		.ctrl  (ctrl)
	);

	// =========================================================================
	// datapath
	// =========================================================================
	reg_file u_reg_file (
		.clk     (clk),
		.arst_n  (arst_n),
		.ra      (ctrl.ra),
		.rb      (ctrl.rb),
		.rt      (ctrl.rt),
		.ra_data (ra_data),
		.rb_data (rb_data),
		.rt_data (rt_data),
		.we      (reg_we),
		.wa      (ctrl.rt), // rt is always the destination.
		.wd      (write_reg_data)
	);

	muxs u_muxs (
		.sub_op_sv         (ctrl.sv),
		.reg_rb_data       (rb_data),
		.reg_rt_data       (rt_data),
		.mem_read_data     (load_data),
		.alu_output        (alu_result),
		.imm_5bit          (instr[rb_hi:rb_lo]),
		.imm_15bit         (instr[imm15_hi:0]),
		.imm_20bit         (instr[imm20_hi:0]),
		.select_alu_src2   (ctrl.src2_sel),
		.select_imm_extend (ctrl.imm_ext),
		.select_write_reg  (ctrl.wb_sel),
		.alu_src2          (alu_src2),
		.write_reg_data    (write_reg_data)
	);

	alu u_alu (
		.op     (ctrl.alu_op),
		.src1   (ra_data),
		.src2   (alu_src2),
		.result (alu_result)
	);

endmodule

`default_nettype wire

//--- sim/tb_cpu.sv
`default_nettype none

module tb_cpu
	import cpu_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int          timeout_cycles = 4000;
	localparam int          reset_wait = 20;
	localparam logic [7:0]  rec_base = 8'h50;    // first store record in the pattern array.
	localparam logic [31:0] prog_limit = 32'h100;
	localparam logic [31:0] data_limit = 32'h140;

	localparam logic [2:0] t_reset = 3'd0;
	localparam logic [2:0] t_fetch = 3'd5;
	localparam logic [2:0] t_bus = 3'd6;

	logic    clk = 1'b0;
	logic    arst_n = 1'b0;
	wb_m2s_t wb_o;
	wb_s2m_t wb_i = '0;

	logic [31:0] pat [256] = '{default: '0};
	logic [7:0]  rec_ptr = rec_base;
	logic [31:0] exp_pc = '0;
	logic [31:0] rng = 32'd34381;
	logic [1:0]  wait_cnt = 2'd0;
	logic        pending = 1'b0;

	string test_names [8] = '{"reset", "imm_forms", "alu_reg_reg", "load_store",
		"r0_fixed", "fetch_sequence", "bus_misc", "spare"};
	int checks [8] = '{default: 0};
	int errs [8] = '{default: 0};
	int tests_run = 0;
	int tests_failed = 0;
	int total_checks = 0;
	int total_errs = 0;

	cpu_top u_dut (
		.clk    (clk),
		.arst_n (arst_n),
		.wb_o   (wb_o),
		.wb_i   (wb_i)
	);

	initial begin
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_value(input logic [2:0] id, input string what,
			input logic [31:0] expected, input logic [31:0] actual);
		checks[id]++;
		assert (actual == expected)
		else begin
			$display("Error: %s %s expected %h actual %h", test_names[id], what,
				expected, actual);
			errs[id]++;
		end
	endtask

	task automatic finish_test(input logic [2:0] id);
		tests_run++;
		if (errs[id] != 0)
			tests_failed++;
		total_checks += checks[id];
		total_errs += errs[id];
		$display("test %s: %0d checks, %0d errors", test_names[id], checks[id], errs[id]);
	endtask

	// =========================================================================
	// Wishbone slave model
	// =========================================================================
	task automatic check_store(input logic [31:0] adr, input logic [31:0] dat);
		logic [2:0] id;
		id = pat[rec_ptr][2:0];
		if (pat[rec_ptr + 8'd1] == '0) begin
			errs[t_bus]++;
			$display("unexpected store of %h to %h after the last record", dat, adr);
		end else begin
			check_value(id, "store address", pat[rec_ptr + 8'd1], adr);
			check_value(id, "store data", pat[rec_ptr + 8'd2], dat);
			rec_ptr = rec_ptr + 8'd3;
			if (pat[rec_ptr][2:0] != id)
				finish_test(id); // last record of this test.
		end
	endtask

	task automatic answer_request();
		wb_i.ack <= 1'b1;
		if (wb_o.we) begin
			check_store(wb_o.adr, wb_o.dat);
		end else if (wb_o.adr < prog_limit) begin
			check_value(t_fetch, "fetch address", exp_pc, wb_o.adr);
			exp_pc = exp_pc + 32'd4;
			wb_i.dat <= pat[wb_o.adr[9:2]];
		end else if (wb_o.adr < data_limit) begin
			wb_i.dat <= pat[wb_o.adr[9:2]]; // preset load data.
		end else begin
			errs[t_bus]++;
			$display("read from unmapped address %h", wb_o.adr);
			wb_i.dat <= '0;
		end
	endtask

	// one clock of the slave, on values from before the edge.
	task automatic serve_cycle();
		if (wb_i.ack) begin
			wb_i.ack <= 1'b0;
		end else if (wb_o.cyc && wb_o.stb) begin
			if (!pending) begin
				rng = xorshift32(rng);
				wait_cnt = rng[1:0];
				pending = 1'b1;
			end
			if (wait_cnt == 2'd0) begin
				pending = 1'b0;
				answer_request();
			end else begin
				wait_cnt = wait_cnt - 2'd1;
			end
		end
	endtask

	// =========================================================================
	// main sequence
	// =========================================================================
	initial begin
		int   cycles;
		logic hung;
		hung = 1'b0;
		$readmemh("sim/cpu_patterns.mem", pat);

		repeat (3) @(posedge clk);
		check_value(t_reset, "cyc in reset", 32'd0, {31'd0, wb_o.cyc});
		check_value(t_reset, "stb in reset", 32'd0, {31'd0, wb_o.stb});
		arst_n <= 1'b1;

		cycles = 0;
		while (!(wb_o.cyc && wb_o.stb) && cycles < reset_wait) begin
			@(posedge clk);
			cycles++;
		end
		if (!(wb_o.cyc && wb_o.stb)) begin
			hung = 1'b1;
			$display("timeout: no fetch request within %0d cycles of reset", reset_wait);
		end else begin
			check_value(t_reset, "first fetch address", 32'd0, wb_o.adr);
			check_value(t_reset, "first fetch we", 32'd0, {31'd0, wb_o.we});
			finish_test(t_reset);

			// run through the whole program area, trailing no-ops included.
			cycles = 0;
			while (exp_pc < prog_limit && cycles < timeout_cycles) begin
				serve_cycle();
				@(posedge clk);
				cycles++;
			end
			if (exp_pc < prog_limit) begin
				hung = 1'b1;
				$display("timeout: program area not fetched to its end after %0d cycles",
					cycles);
			end else begin
				assert (pat[rec_ptr + 8'd1] == '0)
				else begin
					errs[t_bus]++;
					$display("expected stores still missing at the end of the program");
				end
			end
		end

		if (hung) begin
			$display(">>> FAIL");
		end else begin
			finish_test(t_fetch);
			finish_test(t_bus);
			$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
				tests_run, tests_failed, total_checks, total_errs);
			if (total_errs == 0)
				$display(">>> PASS");
			else
				$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/cpu_patterns.mem
// words 00-3f program (two per line), 40-4f load data at byte 0x100,
// from 50 on store records: test id, store address, store value; address 0 ends the list.
@00
44100800 442FFFF0  // movi r1 0x800, movi r2 -16
14208000 44312345  // swi r2 [r1+0], movi r3 0x12345
14308001 5041FFFD  // swi r3 [r1+1], addi r4 r3 -3
14408002 5851C001  // swi r4 [r1+2], ori r5 r3 0x4001
14508003 48619000  // swi r5 [r1+3], slli r6 r3 4
14608004 40718800  // swi r6 [r1+4], add r7 r3 r2
14708005 40818801  // swi r7 [r1+5], sub r8 r3 r2
14808006 40418005  // swi r8 [r1+6], sub rt form r4 = r3 - r4
14408007 40918802  // swi r4 [r1+7], and r9 r3 r2
14908008 40A18803  // swi r9 [r1+8], xor r10 r3 r2
14A08009 40B29804  // swi r10 [r1+9], or r11 r5 r6
14B0800A 40C11009  // swi r11 [r1+10], srl r12 r2 r4
14C0800B 40D19500  // swi r12 [r1+11], add r13 r3 r5 sv 1
14D0800C 40E19600  // swi r13 [r1+12], add r14 r3 r5 sv 2
14E0800D 40F19700  // swi r14 [r1+13], add r15 r3 r5 sv 3
14F0800E 45000100  // swi r15 [r1+14], movi r16 0x100
05180002 45200A00  // lwi r17 [r16+2], movi r18 0xa00
15197FFF 05380005  // swi r17 [r18-1], lwi r19 [r16+5]
15390003 50018001  // swi r19 [r18+3], addi r0 r3 1
1400800F           // swi r0 [r1+15]
@40
A0000000 A0000001 CAFEF00D A0000003
A0000004 0BADBEEF A0000006 A0000007
@50
1 00000800 FFFFFFF0
1 00000804 00012345
1 00000808 00012342
1 0000080C 00016345
1 00000810 00123450
2 00000814 00012335
2 00000818 00012355
2 0000081C 00000003
2 00000820 00012340
2 00000824 FFFEDCB5
2 00000828 00137755
2 0000082C 1FFFFFFE
2 00000830 0003E9CF
2 00000834 0006B059
2 00000838 000C3D6D
3 000009FC CAFEF00D
3 00000A0C 0BADBEEF
4 0000083C 00000000

//--- src.f
common/cpu_pkg.sv
control/instr_decoder.sv
control/bus_ctrl.sv
datapath/reg_file.sv
datapath/alu.sv
datapath/muxs.sv
verilog/cpu_top.sv
sim/tb_cpu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator.
set -e
cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log

verilator --binary --assert --timing -f src.f --top-module tb_cpu -Mdir "$build_dir" -o tb_cpu
"./$build_dir/tb_cpu" | tee "$log_file"

if grep -qx ">>> PASS" "$log_file"; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
